/* scr_ram.f */
hdl/scr_ram_pkg.sv
hdl/subst_perm.sv
hdl/keystream_gen.sv
hdl/ram_1p.sv
hdl/scr_ram.sv
verif/scr_ram_tb.sv

/* Makefile */
# Verilator build and run of the scrambled memory testbench

TOP := scr_ram_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Mdir obj_dir --top-module $(TOP) -f scr_ram.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* verif/scr_ram_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the scrambled memory: operation table, LFSR write data,
// reference memory model, response checks and a watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scr_ram_tb;
  import scr_ram_pkg::*;

  localparam time                  ClkPeriod     = 100ns;
  localparam time                  InDelay       = 10ns;
  localparam int                   ResetCycles   = 3;
  localparam int                   WatchdogSlack = 20;
  localparam int                   NumTests      = 6;
  localparam logic [31:0]          LfsrSeed      = 32'h96d00929;
  localparam logic [31:0]          LfsrTaps      = 32'h8020_0003;
  localparam logic [DataWidth-1:0] FullMask      = '1;
  localparam logic [1:0]           OpIdle        = 2'd0;
  localparam logic [1:0]           OpRead        = 2'd1;
  localparam logic [1:0]           OpWrite       = 2'd2;

  // One table row is one cycle of requester activity
  typedef struct packed {
    logic [1:0]           op;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] mask;
    logic                 key_valid;
    logic                 expect_gnt;
    int                   test;
  } row_t;

  // Expected response of a granted read, known marks the bits ever written
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
    logic [DataWidth-1:0] known;
    int                   test;
  } read_t;

  logic                  clk;
  logic                  rst_n;
  logic                  key_valid;
  logic [KeyWidth-1:0]   key;
  logic [NonceWidth-1:0] nonce;
  logic                  req;
  logic                  gnt;
  logic                  write;
  logic [AddrWidth-1:0]  addr;
  logic [DataWidth-1:0]  wdata;
  logic [DataWidth-1:0]  wmask;
  logic [DataWidth-1:0]  rdata;
  logic                  rvalid;
  logic [AddrWidth-1:0]  raddr;

  row_t                 table_q[$];
  read_t                exp_reads[$];
  logic [DataWidth-1:0] model_mem [Depth];
  logic [DataWidth-1:0] model_known [Depth];
  logic [31:0]          lfsr_state;
  logic                 expect_rvalid;
  bit                   table_ready;
  int                   test_errors [NumTests];
  int                   tests_failed;
  int                   num_checks;
  int                   num_errors;

  always #(ClkPeriod / 2) clk = ~clk;

  scr_ram i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .key_valid_i (key_valid),
    .key_i       (key),
    .nonce_i     (nonce),
    .req_i       (req),
    .gnt_o       (gnt),
    .write_i     (write),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .wmask_i     (wmask),
    .rdata_o     (rdata),
    .rvalid_o    (rvalid),
    .raddr_o     (raddr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois step, the bit shifted out feeds back through the taps
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LfsrTaps) : (state >> 1);
  endfunction

  // Gathers n bits, one LFSR step for each bit
  task automatic take_bits(input int n, output logic [63:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset values";
      1:       return "round trip";
      2:       return "byte masks";
      3:       return "collision forwarding";
      4:       return "address bijection";
      default: return "key gating";
    endcase
  endfunction

  task automatic report_mismatch(input string msg, input int test);
    $display("mismatch at %0t: %s [%s]", $time, msg, test_name(test));
    test_errors[test]++;
    num_errors++;
  endtask

  task automatic report_test(input int id);
    if (test_errors[id] == 0) begin
      $display("test %0d %s: ok", id, test_name(id));
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", id, test_name(id), test_errors[id]);
    end
  endtask

  // A request is granted exactly when it is issued with a valid key
  task automatic add_row(input logic [1:0] op, input logic [AddrWidth-1:0] a,
                         input logic [DataWidth-1:0] m, input logic kv, input int test);
    row_t r;
    r.op         = op;
    r.addr       = a;
    r.mask       = m;
    r.key_valid  = kv;
    r.expect_gnt = (op != OpIdle) && kv;
    r.test       = test;
    table_q.push_back(r);
  endtask

  task automatic add_gap(input int n, input int test);
    for (int i = 0; i < n; i++) begin
      add_row(OpIdle, '0, '0, 1'b1, test);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Operation table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [AddrWidth-1:0] words [4];
    logic [DataWidth-1:0] masks [4];
    words = '{8'h00, 8'h5a, 8'hff, 8'h81};
    masks = '{32'h0000_00ff, 32'hff00_ff00, 32'hffff_0000, 32'h00ff_ff00};
    // Full writes, a gap so that all of them reach the array, then reads
    foreach (words[i]) begin
      add_row(OpWrite, words[i], FullMask, 1'b1, 1);
    end
    add_gap(2, 1);
    foreach (words[i]) begin
      add_row(OpRead, words[i], '0, 1'b1, 1);
    end
    add_gap(2, 1);
    // Partial byte writes over the words above
    foreach (words[i]) begin
      add_row(OpWrite, words[i], masks[i], 1'b1, 2);
    end
    add_gap(1, 2);
    foreach (words[i]) begin
      add_row(OpRead, words[i], '0, 1'b1, 2);
    end
    // A masked write read straight back, so the merge happens on forwarding
    add_row(OpWrite, 8'h5a, 32'hff00_0000, 1'b1, 2);
    add_row(OpRead, 8'h5a, '0, 1'b1, 2);
    add_gap(2, 2);
    // Write A then read A, and write A, read B, write C, read A, read C
    add_row(OpWrite, 8'h33, FullMask, 1'b1, 3);
    add_row(OpRead, 8'h33, '0, 1'b1, 3);
    add_gap(1, 3);
    add_row(OpWrite, 8'h44, FullMask, 1'b1, 3);
    add_row(OpRead, 8'h5a, '0, 1'b1, 3);
    add_row(OpWrite, 8'h66, FullMask, 1'b1, 3);
    add_row(OpRead, 8'h44, '0, 1'b1, 3);
    add_row(OpRead, 8'h66, '0, 1'b1, 3);
    add_gap(2, 3);
    // Every address once, then all of them read back
    for (int a = 0; a < Depth; a++) begin
      add_row(OpWrite, AddrWidth'(a), FullMask, 1'b1, 4);
    end
    for (int a = 0; a < Depth; a++) begin
      add_row(OpRead, AddrWidth'(a), '0, 1'b1, 4);
    end
    add_gap(2, 4);
    // Requests without a valid key must leave the word untouched
    add_row(OpWrite, 8'h77, FullMask, 1'b1, 5);
    add_row(OpWrite, 8'h77, FullMask, 1'b0, 5);
    add_row(OpRead, 8'h77, '0, 1'b0, 5);
    add_row(OpIdle, '0, '0, 1'b0, 5);
    add_row(OpRead, 8'h77, '0, 1'b1, 5);
    add_gap(2, 5);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row driver and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(input row_t r);
    logic [63:0]          bits;
    logic [DataWidth-1:0] data;
    read_t                exp;
    @(posedge clk);
    #InDelay;
    data = '0;
    // The low byte carries the address, so the sweep's words are all distinct
    if (r.op == OpWrite) begin
      take_bits(24, bits);
      data = {bits[23:0], r.addr};
    end
    req       = (r.op != OpIdle);
    write     = (r.op == OpWrite);
    addr      = r.addr;
    wdata     = data;
    wmask     = r.mask;
    key_valid = r.key_valid;
    @(negedge clk);
    num_checks++;
    if (gnt !== r.expect_gnt) begin
      report_mismatch($sformatf("gnt_o %b, expected %b", gnt, r.expect_gnt), r.test);
    end
    // Response of the read granted one cycle earlier
    num_checks++;
    if (rvalid !== expect_rvalid) begin
      report_mismatch($sformatf("rvalid_o %b, expected %b", rvalid, expect_rvalid), r.test);
    end
    if (rvalid === 1'b1 && exp_reads.size() > 0) begin
      exp = exp_reads.pop_front();
      num_checks += 2;
      if (raddr !== exp.addr) begin
        report_mismatch($sformatf("raddr_o %h, expected %h", raddr, exp.addr), exp.test);
      end
      if (((rdata ^ exp.data) & exp.known) !== '0) begin
        report_mismatch($sformatf("rdata_o %h, expected %h at address %h",
                                  rdata, exp.data, exp.addr), exp.test);
      end
    end else if (rvalid !== 1'b1) begin
      num_checks++;
      if (rdata !== '0) begin
        report_mismatch($sformatf("rdata_o %h without rvalid_o", rdata), r.test);
      end
    end
    // Model follows program order, a write counts from its grant on
    if (r.expect_gnt && r.op == OpWrite) begin
      model_mem[r.addr]   = (model_mem[r.addr] & ~r.mask) | (data & r.mask);
      model_known[r.addr] = model_known[r.addr] | r.mask;
    end
    expect_rvalid = r.expect_gnt && (r.op == OpRead);
    if (expect_rvalid) begin
      exp.addr  = r.addr;
      exp.data  = model_mem[r.addr];
      exp.known = model_known[r.addr];
      exp.test  = r.test;
      exp_reads.push_back(exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [63:0] bits;
    int          prev_test;
    clk           = 1'b0;
    rst_n         = 1'b0;
    req           = 1'b0;
    write         = 1'b0;
    addr          = '0;
    wdata         = '0;
    wmask         = '0;
    key_valid     = 1'b0;
    expect_rvalid = 1'b0;
    lfsr_state    = LfsrSeed;
    take_bits(KeyWidth, bits);
    key = bits;
    take_bits(NonceWidth, bits);
    nonce = bits[NonceWidth-1:0];
    for (int a = 0; a < Depth; a++) begin
      model_mem[a]   = '0;
      model_known[a] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #InDelay;
    rst_n = 1'b1;
    @(negedge clk);
    num_checks++;
    if (rvalid !== 1'b0 || rdata !== '0) begin
      report_mismatch($sformatf("rvalid_o %b rdata_o %h after reset", rvalid, rdata), 0);
    end
    report_test(0);
    prev_test = table_q[0].test;
    foreach (table_q[i]) begin
      if (table_q[i].test != prev_test) begin
        report_test(prev_test);
        prev_test = table_q[i].test;
      end
      run_row(table_q[i]);
    end
    report_test(prev_test);
    if (exp_reads.size() != 0) begin
      $display("error: %0d granted reads never got a response", exp_reads.size());
      num_errors++;
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             NumTests, tests_failed, num_checks, num_errors);
    if (num_errors == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Bounded by the table length, reset and drain fit in the slack
  initial begin
    wait (table_ready);
    repeat (table_q.size() + WatchdogSlack) @(posedge clk);
    $display("error: watchdog expired before the operation table was done");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* hdl/scr_ram.sv */
////////////////////////////////////////////////////////////////////////////
// Scrambled single-port memory: address mapping, counter-mode data
// scrambling with byte diffusion, delayed writes and collision forwarding
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scr_ram (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               key_valid_i,
  input  logic [scr_ram_pkg::KeyWidth-1:0]   key_i,
  input  logic [scr_ram_pkg::NonceWidth-1:0] nonce_i,
  input  logic                               req_i,
  output logic                               gnt_o,
  input  logic                               write_i,
  input  logic [scr_ram_pkg::AddrWidth-1:0]  addr_i,
  input  logic [scr_ram_pkg::DataWidth-1:0]  wdata_i,
  input  logic [scr_ram_pkg::DataWidth-1:0]  wmask_i,
  output logic [scr_ram_pkg::DataWidth-1:0]  rdata_o,
  output logic                               rvalid_o,
  output logic [scr_ram_pkg::AddrWidth-1:0]  raddr_o
);
  import scr_ram_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Request strobes and write scheduling
  ////////////////////////////////////////////////////////////////////////////

  logic                 read_en;
  logic                 write_en_d;
  logic                 write_en_q;
  logic                 write_pending_d;
  logic                 write_pending_q;
  logic                 addr_collision_d;
  logic                 addr_collision_q;
  logic                 rw_collision;
  logic                 mem_req;
  logic                 mem_write;
  logic                 ks_valid;
  logic [AddrWidth-1:0] waddr_q;
  logic [AddrWidth-1:0] raddr_q;
  logic [AddrWidth-1:0] addr_mux;
  logic [AddrWidth-1:0] addr_scr;
  logic [DataWidth-1:0] wdata_q;
  logic [DataWidth-1:0] wmask_q;
  logic [DataWidth-1:0] wdata_scr_d;
  logic [DataWidth-1:0] wdata_scr_q;
  logic [DataWidth-1:0] wdata_scr;
  logic [DataWidth-1:0] keystream;
  logic [DataWidth-1:0] rdata_scr;
  logic [DataWidth-1:0] rdata_plain;
  logic [DataWidth-1:0] rdata_merged;

  // Requests only pass while the key is valid
  assign gnt_o      = req_i & key_valid_i;
  assign read_en    = gnt_o & ~write_i;
  assign write_en_d = gnt_o & write_i;

  // A write sits in the delay register for one cycle, and a granted read in
  // that cycle pushes it into the holding register until the port is free
  assign rw_collision = write_en_q & read_en;
  assign mem_write    = (write_en_q | write_pending_q) & ~read_en;
  assign mem_req      = read_en | mem_write;

  // Clear on the write to memory, set when a read takes the port first
  assign write_pending_d = mem_write    ? 1'b0 :
                           rw_collision ? 1'b1 :
                                          write_pending_q;

  // A read of the waiting write's address sees stale memory contents,
  // so the held plain data is merged in on the response
  assign addr_collision_d = read_en & (write_en_q | write_pending_q) & (addr_i == waddr_q);

  ////////////////////////////////////////////////////////////////////////////
  // Address mapping
  ////////////////////////////////////////////////////////////////////////////

  // The waiting write only gets the port when no read is granted
  assign addr_mux = read_en ? addr_i : waddr_q;

  // Upper nonce byte keys a bijective mapping of the address
  subst_perm #(
    .Width     (AddrWidth),
    .NumRounds (NumAddrRounds),
    .Decrypt   (1'b0)
  ) i_addr_scr (
    .data_i (addr_mux),
    .key_i  (nonce_i[NonceWidth-1 -: AddrWidth]),
    .data_o (addr_scr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Keystream and data scrambling
  ////////////////////////////////////////////////////////////////////////////

  // Counter block is the lower nonce bits followed by the plain address
  // The keystream belongs to the request granted in the previous cycle
  keystream_gen i_keystream_gen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (gnt_o),
    .block_i     ({nonce_i[NonceWidth-AddrWidth-1:0], addr_i}),
    .key_i       (key_i),
    .keystream_o (keystream),
    .valid_o     (ks_valid)
  );

  // Write side: XOR first, then diffuse inside each byte
  // Diffusion stays within a byte to keep byte masks meaningful
  for (genvar k = 0; k < DataWidth / 8; k++) begin : gen_wbytes
    logic [7:0] wbyte_xor;

    assign wbyte_xor = wdata_q[k*8 +: 8] ^ keystream[k*8 +: 8];

    subst_perm #(
      .Width     (8),
      .NumRounds (NumByteRounds),
      .Decrypt   (1'b0)
    ) i_byte_enc (
      .data_i (wbyte_xor),
      .key_i  (8'h00),
      .data_o (wdata_scr_d[k*8 +: 8])
    );
  end

  // Held scrambled word wins, the keystream now belongs to another request
  assign wdata_scr = write_pending_q ? wdata_scr_q : wdata_scr_d;

  // Read side undoes the two steps in reverse order
  for (genvar k = 0; k < DataWidth / 8; k++) begin : gen_rbytes
    logic [7:0] rbyte_dec;

    subst_perm #(
      .Width     (8),
      .NumRounds (NumByteRounds),
      .Decrypt   (1'b1)
    ) i_byte_dec (
      .data_i (rdata_scr[k*8 +: 8]),
      .key_i  (8'h00),
      .data_o (rbyte_dec)
    );

    assign rdata_plain[k*8 +: 8] = rbyte_dec ^ keystream[k*8 +: 8];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read response
  ////////////////////////////////////////////////////////////////////////////

  // Last cycle's grant minus last cycle's write grant is last cycle's read
  assign rvalid_o = ks_valid & ~write_en_q;

  // Masked bits of a colliding write replace the old memory word
  assign rdata_merged = addr_collision_q ? ((rdata_plain & ~wmask_q) | (wdata_q & wmask_q)) :
                                           rdata_plain;

  assign rdata_o = rvalid_o ? rdata_merged : '0;
  assign raddr_o = raddr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_en_q       <= 1'b0;
      write_pending_q  <= 1'b0;
      addr_collision_q <= 1'b0;
    end else begin
      write_en_q       <= write_en_d;
      write_pending_q  <= write_pending_d;
      addr_collision_q <= addr_collision_d;
    end
  end

  // Payload of the delayed write and of the read response
  always_ff @(posedge clk_i) begin
    if (read_en) begin
      raddr_q <= addr_i;
    end
    if (write_en_d) begin
      waddr_q <= addr_i;
      wmask_q <= wmask_i;
      wdata_q <= wdata_i;
    end
    // Catch the scrambled word while its keystream is still on the bus
    if (rw_collision) begin
      wdata_scr_q <= wdata_scr_d;
    end
  end

  ram_1p i_ram_1p (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .write_i (mem_write),
    .addr_i  (addr_scr),
    .wdata_i (wdata_scr),
    .wmask_i (wmask_q),
    .rdata_o (rdata_scr)
  );

  // Response timing relies on the valid path through the keystream block
  a_rvalid_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> rvalid_o == $past(read_en));

  // A memory write cycle is never one in which a read was granted
  a_no_write_on_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_write |=> !rvalid_o);

  // The pending flag only follows a delayed or an already waiting write
  a_pending_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
    write_pending_q |-> $past(write_en_q | write_pending_q));

endmodule

/* hdl/ram_1p.sv */
////////////////////////////////////////////////////////////////////////////
// Single-port word memory with bitwise write mask and registered read data
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ram_1p (
  input  logic                              clk_i,
  input  logic                              req_i,
  input  logic                              write_i,
  input  logic [scr_ram_pkg::AddrWidth-1:0] addr_i,
  input  logic [scr_ram_pkg::DataWidth-1:0] wdata_i,
  input  logic [scr_ram_pkg::DataWidth-1:0] wmask_i,
  output logic [scr_ram_pkg::DataWidth-1:0] rdata_o
);
  import scr_ram_pkg::*;

  // Storage array, contents are undefined until written
  logic [DataWidth-1:0] mem_q [Depth];

  // Read data register, holds the last word read
  logic [DataWidth-1:0] rdata_q;

  // Word currently addressed, used by both the write merge and the read
  logic [DataWidth-1:0] mem_word;

  assign mem_word = mem_q[addr_i];

  // Write path
  // Masked bits take the new data, the others keep their stored value
  always_ff @(posedge clk_i) begin
    if (req_i && write_i) begin
      mem_q[addr_i] <= (mem_word & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // Read path
  // The word shows up on rdata_o in the cycle after the request
  always_ff @(posedge clk_i) begin
    if (req_i && !write_i) begin
      rdata_q <= mem_word;
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* hdl/keystream_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Reduced-round 32-bit block cipher for counter-mode keystream generation,
// with a pipeline register after half of the rounds
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module keystream_gen (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             valid_i,
  input  logic [31:0]                      block_i,
  input  logic [scr_ram_pkg::KeyWidth-1:0] key_i,
  output logic [31:0]                      keystream_o,
  output logic                             valid_o
);
  import scr_ram_pkg::*;

  // Round key r is a 32-bit window of the key rotated by 19*r bits
  // The odd step makes every key bit take part over the four rounds
  function automatic logic [31:0] round_key(input logic [KeyWidth-1:0] key, input int rnd);
    logic [2*KeyWidth-1:0] key_dbl;
    key_dbl = {key, key};
    return key_dbl[(rnd * 19) % KeyWidth +: 32];
  endfunction

  // One cipher round: key mix, eight S-boxes, then the bit permutation
  function automatic logic [31:0] cipher_round(input logic [31:0] state,
                                               input logic [31:0] rkey);
    logic [31:0] mixed;
    logic [31:0] permuted;
    mixed    = state ^ rkey;
    permuted = '0;
    for (int n = 0; n < 8; n++) begin
      mixed[4*n +: 4] = SBox4[mixed[4*n +: 4]];
    end
    for (int b = 0; b < 32; b++) begin
      permuted[spn_perm(b, 32)] = mixed[b];
    end
    return permuted;
  endfunction

  logic [31:0] first_half;
  logic [31:0] half_q;
  logic [31:0] second_half;
  logic        valid_q;

  // Rounds before the register
  always_comb begin
    first_half = block_i;
    for (int r = 0; r < NumCipherRounds / 2; r++) begin
      first_half = cipher_round(first_half, round_key(key_i, r));
    end
  end

  // Only load on a request so that the state does not toggle when idle
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      half_q <= first_half;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Remaining rounds finish in the cycle after the request
  always_comb begin
    second_half = half_q;
    for (int r = NumCipherRounds / 2; r < NumCipherRounds; r++) begin
      second_half = cipher_round(second_half, round_key(key_i, r));
    end
  end

  assign keystream_o = second_half;
  assign valid_o     = valid_q;

  // The keystream of a request is marked valid exactly one cycle later
  a_valid_delay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> valid_o == $past(valid_i));

endmodule

/* hdl/subst_perm.sv */
////////////////////////////////////////////////////////////////////////////
// Keyed substitution/permutation network that is purely combinational
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module subst_perm #(
  parameter int Width     = 8,
  parameter int NumRounds = 2,
  parameter bit Decrypt   = 1'b0
) (
  input  logic [Width-1:0] data_i,
  input  logic [Width-1:0] key_i,
  output logic [Width-1:0] data_o
);
  import scr_ram_pkg::*;

  // Number of S-box lanes in one word
  // The width must be a multiple of four for the nibble split to work
  localparam int NumLanes = Width / 4;

  logic [Width-1:0] state;
  logic [Width-1:0] shuffled;

  always_comb begin
    state    = data_i;
    shuffled = '0;
    for (int r = 0; r < NumRounds; r++) begin
      if (!Decrypt) begin
        // The forward round mixes in the key, substitutes, then permutes
        state = state ^ key_i;
        for (int n = 0; n < NumLanes; n++) begin
          state[4*n +: 4] = SBox4[state[4*n +: 4]];
        end
        for (int b = 0; b < Width; b++) begin
          shuffled[spn_perm(b, Width)] = state[b];
        end
        state = shuffled;
      end else begin
        // Inverse round runs the three steps backwards
        // Undo the permutation by gathering from the forward destinations
        for (int b = 0; b < Width; b++) begin
          shuffled[b] = state[spn_perm(b, Width)];
        end
        for (int n = 0; n < NumLanes; n++) begin
          shuffled[4*n +: 4] = SBox4Inv[shuffled[4*n +: 4]];
        end
        // Same key each round, so the order of rounds does not matter for the key
        state = shuffled ^ key_i;
      end
    end
    data_o = state;
  end

  // Static check on the nibble split
  // A width that is not a multiple of four would leave bits outside any S-box
  initial begin
    assert (Width % 4 == 0 && Width >= 4)
      else $error("subst_perm width must be a multiple of four");
    assert (NumRounds >= 0)
      else $error("subst_perm round count must not be negative");
  end

endmodule

/* hdl/scr_ram_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths, depth and round counts of the scrambled memory, plus the
// 4-bit S-box tables and bit permutation used by both cipher blocks
////////////////////////////////////////////////////////////////////////////

package scr_ram_pkg;

  // Memory geometry, the depth must stay a power of two so that the
  // address mapping remains a bijection over the whole address space
  localparam int DataWidth = 32;
  localparam int Depth     = 256;
  localparam int AddrWidth = 8;

  // Key material for the keystream cipher and the counter block nonce
  localparam int KeyWidth   = 64;
  localparam int NonceWidth = 32;

  // Round counts, the keystream cipher is split half-way by a register
  localparam int NumCipherRounds = 4;
  localparam int NumByteRounds   = 2;
  localparam int NumAddrRounds   = 2;

  // 4-bit S-box, nibble 0 sits in the low bits of the word
  localparam logic [15:0][3:0] SBox4    = 64'h2174_8fe3_da09_b65c;
  // Inverse of the S-box above
  localparam logic [15:0][3:0] SBox4Inv = 64'ha970_364b_d21c_8fe5;

  // Bit permutation of the diffusion layer, bit idx moves to the returned position
  // For any width that is a multiple of four, width/4 and width-1 are coprime,
  // so the mapping below is always a bijection
  function automatic int spn_perm(input int idx, input int width);
    int dst;
    if (idx == width - 1) begin
      dst = idx;
    end else begin
      dst = (idx * (width / 4)) % (width - 1);
    end
    return dst;
  endfunction

endpackage
